//--- include/corr_regs.svh
// Host register map of the correlator with its word addresses and bit positions.
`ifndef CORR_REGS_SVH
`define CORR_REGS_SVH

// configuration and status registers.
`define REG_CTRL       8'h00
`define REG_INVERT     8'h01
`define REG_EDGE       8'h02
`define REG_INTEG_LEN  8'h03
`define REG_STATUS     8'h04

// the count of line i sits at base + i.
`define REG_COUNT_BASE 8'h10
// correlation of baseline b and tap t sits at base + b * TAPS + t.
`define REG_CORR_BASE  8'h40

// bit positions inside CTRL and STATUS.
`define CTRL_RUN_BIT    0
`define STATUS_BUSY_BIT 16

`endif

//--- design/corr_pkg.sv
// Correlator package with the configuration, Wishbone and status types and the size limits.
package corr_pkg;

	// ======================================================================
	// size limits
	// ======================================================================

	// the upper bound on the number of pulse lines sets the mask widths.
	localparam int MAX_INPUTS = 8;

	// Wishbone word-address and data widths.
	localparam int WB_AW = 8;
	localparam int WB_DW = 32;
	localparam int WB_SW = WB_DW / 8;

	// ======================================================================
	// types
	// ======================================================================

	// host configuration as written through the register slave.
	typedef struct packed {
		logic                  run;
		logic [MAX_INPUTS-1:0] invert_mask;
		logic [MAX_INPUTS-1:0] edge_mask;
		logic [31:0]           integ_len;
	} corr_cfg_t;

	// master to slave request of a Wishbone classic cycle.
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_AW-1:0] adr;
		logic [WB_DW-1:0] dat_w;
		logic [WB_SW-1:0] sel;
	} wb_req_t;

	// slave to master response.
	typedef struct packed {
		logic             ack;
		logic [WB_DW-1:0] dat_r;
	} wb_rsp_t;

	// state of the integration timer as the host sees it.
	typedef struct packed {
		logic        busy;
		logic [15:0] frame_count;
	} corr_status_t;

endpackage

//--- design/line_conditioner.sv
// Line conditioner that synchronizes, inverts and optionally edge-detects the pulse lines.
`timescale 1ns/100ps

module line_conditioner #(
	parameter int NUM_INPUTS = 4
) (
	input  logic                  intclk,
	input  logic                  rst,
	input  logic [NUM_INPUTS-1:0] line_in,
	input  corr_pkg::corr_cfg_t   cfg,
	output logic [NUM_INPUTS-1:0] pulse
);

	logic [NUM_INPUTS-1:0] sync1;
	logic [NUM_INPUTS-1:0] sync2;
	logic [NUM_INPUTS-1:0] hist;
	logic [NUM_INPUTS-1:0] eff;
	logic [NUM_INPUTS-1:0] inv;
	logic [NUM_INPUTS-1:0] edg;

	assign inv = cfg.invert_mask[NUM_INPUTS-1:0];
	assign edg = cfg.edge_mask[NUM_INPUTS-1:0];

	// effective level of each line after the polarity select.
	assign eff = sync2 ^ inv;

	// ======================================================================
	// synchronizer and output register
	// ======================================================================

	always_ff @(posedge intclk) begin
		if (rst) begin
			sync1 <= '0;
			sync2 <= '0;
			hist  <= '0;
			pulse <= '0;
		end else begin
			sync1 <= line_in;
			sync2 <= sync1;
			hist  <= eff;
			// in edge mode only a low to high step gives a pulse.
			pulse <= eff & ~(hist & edg);
		end
	end

endmodule

//--- design/integration_timer.sv
// Integration timer that frames the windows, strobes their start and end and counts frames.
`timescale 1ns/100ps

module integration_timer (
	input  logic                   intclk,
	input  logic                   rst,
	input  corr_pkg::corr_cfg_t    cfg,
	output logic                   win_start,
	output logic                   win_end,
	output corr_pkg::corr_status_t status
);

	logic        busy;
	logic [31:0] remaining;
	logic [31:0] len_m1;
	logic [15:0] frame_count;

	// windows shorter than two cycles are stretched so the strobes never coincide.
	assign len_m1 = (cfg.integ_len < 32'd2) ? 32'd1 : cfg.integ_len - 32'd1;

	// remaining holds the window cycles still to come after the current one.
	always_ff @(posedge intclk) begin
		if (rst) begin
			busy        <= 1'b0;
			win_start   <= 1'b0;
			win_end     <= 1'b0;
			remaining   <= '0;
			frame_count <= '0;
		end else begin
			win_start <= 1'b0;
			win_end   <= 1'b0;
			if (!busy) begin
				if (cfg.run) begin
					busy      <= 1'b1;
					win_start <= 1'b1;
					remaining <= len_m1;
				end
			end else if (remaining == '0) begin
				frame_count <= frame_count + 16'd1;
				// a cleared run bit stops the timer here at the end of the window.
				if (cfg.run) begin
					win_start <= 1'b1;
					remaining <= len_m1;
				end else begin
					busy <= 1'b0;
				end
			end else begin
				win_end   <= (remaining == 32'd1);
				remaining <= remaining - 32'd1;
			end
		end
	end

	assign status = '{busy: busy, frame_count: frame_count};

endmodule

//--- design/pulse_counter.sv
// Pulse counter with one saturating active-cycle counter per line and a window-end snapshot.
`timescale 1ns/100ps

module pulse_counter #(
	parameter int NUM_INPUTS = 4,
	parameter int RESOLUTION = 16
) (
	input  logic                             intclk,
	input  logic                             rst,
	input  logic [NUM_INPUTS-1:0]            pulse,
	input  logic                             win_start,
	input  logic                             win_end,
	output logic [NUM_INPUTS*RESOLUTION-1:0] counts
);

	logic                  active;
	logic                  snap_due;
	logic [RESOLUTION-1:0] cnt [NUM_INPUTS];

	// the start cycle restarts the count with its own sample.
	always_ff @(posedge intclk) begin
		if (rst) begin
			active   <= 1'b0;
			snap_due <= 1'b0;
			counts   <= '0;
			for (int i = 0; i < NUM_INPUTS; i++)
				cnt[i] <= '0;
		end else begin
			if (win_start)
				active <= 1'b1;
			else if (win_end)
				active <= 1'b0;
			snap_due <= win_end;
			for (int i = 0; i < NUM_INPUTS; i++) begin
				if (win_start)
					cnt[i] <= RESOLUTION'(pulse[i]);
				else if (active && pulse[i] && !(&cnt[i]))
					cnt[i] <= cnt[i] + 1'b1;
				if (snap_due)
					counts[i*RESOLUTION +: RESOLUTION] <= cnt[i];
			end
		end
	end

endmodule

//--- design/lag_correlator.sv
// Lag correlator that counts the coincidences of every baseline at every lag into a snapshot.
`timescale 1ns/100ps

module lag_correlator #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_CROSS  = 2,
	parameter int RESOLUTION = 16
) (
	input  logic              intclk,
	input  logic              rst,
	input  logic [NUM_INPUTS-1:0] pulse,
	input  logic              win_start,
	input  logic              win_end,
	output logic [NUM_INPUTS*(NUM_INPUTS-1)/2*(2*LAG_CROSS-1)*RESOLUTION-1:0] corr
);

	localparam int TAPS          = 2 * LAG_CROSS - 1;
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int NUM_CNT       = NUM_BASELINES * TAPS;
	localparam int DEPTH         = (LAG_CROSS > 1) ? LAG_CROSS - 1 : 1;

	logic [DEPTH-1:0][NUM_INPUTS-1:0]     dl;
	logic [LAG_CROSS-1:0][NUM_INPUTS-1:0] tap;
	logic [NUM_CNT-1:0]                   hit;
	logic                                 active;
	logic                                 snap_due;
	logic [RESOLUTION-1:0]                cnt [NUM_CNT];

	// ======================================================================
	// delay lines
	// ======================================================================

	// tap k is the sample of k cycles ago and reads zero before the window began.
	always_comb begin
		tap[0] = pulse;
		for (int k = 1; k < LAG_CROSS; k++)
			tap[k] = win_start ? '0 : dl[k-1];
	end

	always_ff @(posedge intclk) begin
		if (rst) begin
			dl <= '0;
		end else begin
			dl[0] <= pulse;
			for (int k = 1; k < DEPTH; k++)
				dl[k] <= tap[k];
		end
	end

	// ======================================================================
	// coincidences
	// ======================================================================

	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_first
		for (genvar j = i + 1; j < NUM_INPUTS; j++) begin : g_second
			localparam int B = i * NUM_INPUTS - i * (i + 1) / 2 + (j - i - 1);
			for (genvar t = 0; t < TAPS; t++) begin : g_tap
				localparam int K = t - (LAG_CROSS - 1);
				if (K >= 0) begin : g_pos
					assign hit[B*TAPS+t] = tap[0][i] & tap[K][j];
				end else begin : g_neg
					assign hit[B*TAPS+t] = tap[0][j] & tap[-K][i];
				end
			end
		end
	end

	// counters saturate at all ones just like the pulse counter.
	always_ff @(posedge intclk) begin
		if (rst) begin
			active   <= 1'b0;
			snap_due <= 1'b0;
			corr     <= '0;
			for (int n = 0; n < NUM_CNT; n++)
				cnt[n] <= '0;
		end else begin
			if (win_start)
				active <= 1'b1;
			else if (win_end)
				active <= 1'b0;
			snap_due <= win_end;
			for (int n = 0; n < NUM_CNT; n++) begin
				if (win_start)
					cnt[n] <= RESOLUTION'(hit[n]);
				else if (active && hit[n] && !(&cnt[n]))
					cnt[n] <= cnt[n] + 1'b1;
				if (snap_due)
					corr[n*RESOLUTION +: RESOLUTION] <= cnt[n];
			end
		end
	end

endmodule

//--- design/wb_corr_regs.sv
// Wishbone classic slave with the configuration registers and the result read-back.
`timescale 1ns/100ps

`include "corr_regs.svh"

module wb_corr_regs #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_CROSS  = 2,
	parameter int RESOLUTION = 16
) (
	input  logic                   intclk,
	input  logic                   rst,
	input  corr_pkg::wb_req_t      wb_req,
	output corr_pkg::wb_rsp_t      wb_rsp,
	output corr_pkg::corr_cfg_t    cfg,
	input  corr_pkg::corr_status_t status,
	input  logic [NUM_INPUTS*RESOLUTION-1:0] counts,
	input  logic [NUM_INPUTS*(NUM_INPUTS-1)/2*(2*LAG_CROSS-1)*RESOLUTION-1:0] corr
);

	localparam int TAPS     = 2 * LAG_CROSS - 1;
	localparam int NUM_CORR = NUM_INPUTS * (NUM_INPUTS - 1) / 2 * TAPS;
	localparam logic [corr_pkg::MAX_INPUTS-1:0] LINE_MASK =
		~({corr_pkg::MAX_INPUTS{1'b1}} << NUM_INPUTS);

	logic                       req;
	logic                       ack;
	logic [corr_pkg::WB_DW-1:0] rdata;
	logic [corr_pkg::WB_DW-1:0] rd_mux;
	logic [corr_pkg::WB_DW-1:0] wmask;
	logic [corr_pkg::WB_DW-1:0] wr_word;

	assign req    = wb_req.cyc & wb_req.stb;
	assign wb_rsp = '{ack: ack, dat_r: rdata};

	// ======================================================================
	// read multiplexer
	// ======================================================================

	always_comb begin
		int cnt_idx;
		int corr_idx;
		cnt_idx  = int'(wb_req.adr) - int'(`REG_COUNT_BASE);
		corr_idx = int'(wb_req.adr) - int'(`REG_CORR_BASE);
		rd_mux   = '0;
		if (wb_req.adr == `REG_CTRL) begin
			rd_mux[`CTRL_RUN_BIT] = cfg.run;
		end else if (wb_req.adr == `REG_INVERT) begin
			rd_mux[corr_pkg::MAX_INPUTS-1:0] = cfg.invert_mask;
		end else if (wb_req.adr == `REG_EDGE) begin
			rd_mux[corr_pkg::MAX_INPUTS-1:0] = cfg.edge_mask;
		end else if (wb_req.adr == `REG_INTEG_LEN) begin
			rd_mux = cfg.integ_len;
		end else if (wb_req.adr == `REG_STATUS) begin
			rd_mux[15:0]             = status.frame_count;
			rd_mux[`STATUS_BUSY_BIT] = status.busy;
		end else if (cnt_idx >= 0 && cnt_idx < NUM_INPUTS) begin
			rd_mux[RESOLUTION-1:0] = counts[cnt_idx*RESOLUTION +: RESOLUTION];
		end else if (corr_idx >= 0 && corr_idx < NUM_CORR) begin
			rd_mux[RESOLUTION-1:0] = corr[corr_idx*RESOLUTION +: RESOLUTION];
		end
	end

	// ======================================================================
	// writes and handshake
	// ======================================================================

	// byte lanes not selected keep the current register contents.
	always_comb begin
		for (int b = 0; b < corr_pkg::WB_SW; b++)
			wmask[8*b +: 8] = {8{wb_req.sel[b]}};
	end

	assign wr_word = (rd_mux & ~wmask) | (wb_req.dat_w & wmask);

	always_ff @(posedge intclk) begin
		if (rst) begin
			ack <= 1'b0;
			cfg <= '0;
		end else begin
			ack <= req & ~ack;
			if (ack && wb_req.we) begin
				case (wb_req.adr)
					`REG_CTRL:      cfg.run <= wr_word[`CTRL_RUN_BIT];
					`REG_INVERT:    cfg.invert_mask <= wr_word[corr_pkg::MAX_INPUTS-1:0] & LINE_MASK;
					`REG_EDGE:      cfg.edge_mask <= wr_word[corr_pkg::MAX_INPUTS-1:0] & LINE_MASK;
					`REG_INTEG_LEN: cfg.integ_len <= wr_word;
					default:        ;
				endcase
			end
		end
	end

	// read data is sampled when the request is first seen.
	always_ff @(posedge intclk) begin
		if (req && !ack)
			rdata <= rd_mux;
	end

endmodule

//--- design/correlator_top.sv
// Photon-pulse correlator top level with a Wishbone classic host port.
`timescale 1ns/100ps

module correlator_top #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_CROSS  = 2,
	parameter int RESOLUTION = 16
) (
	input  logic                  intclk,
	input  logic                  rst,
	input  logic [NUM_INPUTS-1:0] line_in,
	input  corr_pkg::wb_req_t     wb_req,
	output corr_pkg::wb_rsp_t     wb_rsp
);

	localparam int TAPS          = 2 * LAG_CROSS - 1;
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;

	if (NUM_INPUTS < 2 || NUM_INPUTS > corr_pkg::MAX_INPUTS) begin : g_bad_inputs
		$error("NUM_INPUTS must lie between 2 and MAX_INPUTS.");
	end
	if (RESOLUTION < 1 || RESOLUTION > 32 || LAG_CROSS < 1) begin : g_bad_sizes
		$error("RESOLUTION must lie between 1 and 32 and LAG_CROSS be at least 1.");
	end

	corr_pkg::corr_cfg_t                       cfg;
	corr_pkg::corr_status_t                    status;
	logic                                      win_start;
	logic                                      win_end;
	logic [NUM_INPUTS-1:0]                     pulse;
	logic [NUM_INPUTS*RESOLUTION-1:0]          counts;
	logic [NUM_BASELINES*TAPS*RESOLUTION-1:0] corr;

	line_conditioner #(.NUM_INPUTS(NUM_INPUTS)) u_cond (
		.intclk(intclk), .rst(rst), .line_in(line_in), .cfg(cfg), .pulse(pulse)
	);

	integration_timer u_timer (
		.intclk(intclk), .rst(rst), .cfg(cfg),
		.win_start(win_start), .win_end(win_end), .status(status)
	);

	pulse_counter #(.NUM_INPUTS(NUM_INPUTS), .RESOLUTION(RESOLUTION)) u_count (
		.intclk(intclk), .rst(rst), .pulse(pulse),
		.win_start(win_start), .win_end(win_end), .counts(counts)
	);

	lag_correlator #(
		.NUM_INPUTS(NUM_INPUTS), .LAG_CROSS(LAG_CROSS), .RESOLUTION(RESOLUTION)
	) u_corr (
		.intclk(intclk), .rst(rst), .pulse(pulse),
		.win_start(win_start), .win_end(win_end), .corr(corr)
	);

	wb_corr_regs #(
		.NUM_INPUTS(NUM_INPUTS), .LAG_CROSS(LAG_CROSS), .RESOLUTION(RESOLUTION)
	) u_regs (
		.intclk(intclk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp),
		.cfg(cfg), .status(status), .counts(counts), .corr(corr)
	);

endmodule

//--- dv/corr_assertions.sv
// Protocol checker for the Wishbone handshake of the register slave and the window strobes.
`timescale 1ns/100ps

module corr_assertions (
	input logic intclk,
	input logic rst,
	input logic req,
	input logic ack,
	input logic win_start,
	input logic win_end
);

	int fail_count = 0;

	// the slave answers with a single acknowledge cycle.
	ack_single: assert property (@(posedge intclk) disable iff (rst) ack |=> !ack)
		else begin
			$error("ack stayed high for two cycles in a row");
			fail_count++;
		end

	ack_after_req: assert property (@(posedge intclk) disable iff (rst) ack |-> $past(req))
		else begin
			$error("ack rose without a request in the cycle before");
			fail_count++;
		end

	strobes_apart: assert property (@(posedge intclk) disable iff (rst) !(win_start && win_end))
		else begin
			$error("win_start and win_end were high in the same cycle");
			fail_count++;
		end

endmodule

bind wb_corr_regs corr_assertions u_bus_chk (
	.intclk(intclk), .rst(rst), .req(wb_req.cyc & wb_req.stb), .ack(wb_rsp.ack),
	.win_start(1'b0), .win_end(1'b0)
);

bind integration_timer corr_assertions u_strobe_chk (
	.intclk(intclk), .rst(rst), .req(1'b0), .ack(1'b0),
	.win_start(win_start), .win_end(win_end)
);

//--- dv/tb_correlator.sv
// Testbench for the photon-pulse correlator that applies a table of line patterns over Wishbone.
`timescale 1ns/100ps

`include "corr_regs.svh"

module tb_correlator;

	localparam int NUM_INPUTS = 4;
	localparam int TAPS       = 3;
	localparam int NUM_BL     = 6;
	localparam int MAX_COUNT  = 2**16 - 1;
	localparam int NUM_ROWS   = 6;
	localparam logic [1:0] MODE_SQUARE = 2'd2;

	typedef struct packed {
		logic              edge_mode;
		logic [3:0]        invert;
		logic [31:0]       integ_len;
		logic [7:0]        period;
		logic [3:0][1:0]   mode;
		logic [3:0][15:0]  exp_count;
		logic [17:0][15:0] exp_corr;
	} row_t;

	logic                  intclk = 1'b0;
	logic                  rst;
	logic [NUM_INPUTS-1:0] line_in = '0;
	corr_pkg::wb_req_t     wb_req;
	corr_pkg::wb_rsp_t     wb_rsp;

	row_t            table_rows [NUM_ROWS];
	logic [3:0][1:0] cur_mode = '0;
	int              cur_period = 4;
	int              phase = 0;
	int              checks = 0;
	int              errors = 0;

	correlator_top dut (
		.intclk(intclk), .rst(rst), .line_in(line_in), .wb_req(wb_req), .wb_rsp(wb_rsp)
	);

	always #20 intclk = ~intclk;

	// square waves of all lines share one phase counter.
	always @(posedge intclk) begin
		#2;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			if (cur_mode[i] == MODE_SQUARE)
				line_in[i] <= (phase % cur_period) < cur_period / 2;
			else
				line_in[i] <= cur_mode[i][0];
		end
		phase = phase + 1;
	end

	// ======================================================================
	// bus access
	// ======================================================================

	task automatic bus_cycle(input logic we, input logic [7:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge intclk);
		#2;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata, sel: 4'hf};
		do begin
			@(negedge intclk);
			waited++;
		end while (!wb_rsp.ack && waited < 16);
		if (!wb_rsp.ack) begin
			$display("bus access to address 0x%02h was never acknowledged", adr);
			errors++;
		end
		rdata = wb_rsp.dat_r;
		@(posedge intclk);
		#2;
		wb_req = '0;
	endtask

	task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
		bus_cycle(1'b0, adr, 32'h0, data);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// ======================================================================
	// reference model
	// ======================================================================

	function automatic int clip(int v);
		return (v > MAX_COUNT) ? MAX_COUNT : v;
	endfunction

	function automatic logic level_high(row_t row, int i);
		return row.mode[i][0] ^ row.invert[i];
	endfunction

	function automatic int model_count(row_t row, int i);
		if (row.edge_mode)
			return (row.mode[i] == MODE_SQUARE) ? int'(row.integ_len / row.period) : 0;
		return clip(level_high(row, i) ? int'(row.integ_len) : 0);
	endfunction

	// rising edges of two squares meet only at lag 0 and only with equal polarity.
	function automatic int model_corr(row_t row, int i, int j, int lag);
		if (row.edge_mode) begin
			if (lag == 0 && row.mode[i] == MODE_SQUARE && row.mode[j] == MODE_SQUARE
					&& row.invert[i] == row.invert[j])
				return int'(row.integ_len / row.period);
			return 0;
		end
		if (level_high(row, i) && level_high(row, j))
			return clip(int'(row.integ_len) - (lag < 0 ? -lag : lag));
		return 0;
	endfunction

	task automatic set_row(input int r, input logic edge_mode, input logic rand_level,
			input logic [3:0] invert, input int len, input int period, input logic [7:0] mode);
		row_t row;
		int b;
		row = '0;
		row.edge_mode  = edge_mode;
		row.invert     = invert;
		row.integ_len  = len;
		row.period     = period;
		row.mode       = mode;
		if (rand_level) begin
			row.invert = 4'($urandom);
			for (int i = 0; i < NUM_INPUTS; i++)
				row.mode[i] = 2'($urandom % 2);
		end
		for (int i = 0; i < NUM_INPUTS; i++)
			row.exp_count[i] = 16'(model_count(row, i));
		b = 0;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int j = i + 1; j < NUM_INPUTS; j++) begin
				for (int t = 0; t < TAPS; t++)
					row.exp_corr[b*TAPS+t] = 16'(model_corr(row, i, j, t - 1));
				b++;
			end
		end
		table_rows[r] = row;
	endtask

	function automatic int run_budget();
		int total;
		total = 10;
		for (int r = 0; r < NUM_ROWS; r++)
			total += 3 * int'(table_rows[r].integ_len) + 200;
		return total;
	endfunction

	// ======================================================================
	// stimulus
	// ======================================================================

	initial begin
		logic [31:0] rd;
		logic [15:0] start_frame;
		int          row_err;
		row_t        row;
		void'($urandom(32'hcf6cf2f5));
		wb_req = '0;
		rst    = 1'b1;
		set_row(0, 1'b0, 1'b0, 4'b0101, 20, 4, 8'b01_00_01_00);
		set_row(1, 1'b0, 1'b1, 4'b0000, 32, 4, 8'h00);
		set_row(2, 1'b0, 1'b1, 4'b0000, 48, 4, 8'h00);
		set_row(3, 1'b1, 1'b0, 4'b0000, 40, 4, 8'b01_10_10_10);
		set_row(4, 1'b1, 1'b0, 4'b1100, 64, 8, 8'b10_01_00_10);
		set_row(5, 1'b0, 1'b0, 4'b0000, 70000, 4, 8'b01_01_01_01);
		repeat (10) @(posedge intclk);
		#2;
		rst = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			row        = table_rows[r];
			row_err    = errors;
			cur_mode   = row.mode;
			cur_period = row.period;
			repeat (8) @(posedge intclk);
			wb_read(`REG_STATUS, rd);
			start_frame = rd[15:0];
			wb_write(`REG_INVERT, 32'hffff_fff0 | row.invert);
			wb_write(`REG_EDGE, row.edge_mode ? 32'hffff_ffff : 32'h0);
			wb_write(`REG_INTEG_LEN, row.integ_len);
			wb_read(`REG_INVERT, rd);
			check_value("INVERT", rd, {28'h0, row.invert});
			wb_read(`REG_EDGE, rd);
			check_value("EDGE", rd, row.edge_mode ? 32'hf : 32'h0);
			wb_read(`REG_INTEG_LEN, rd);
			check_value("INTEG_LEN", rd, row.integ_len);
			wb_write(`REG_CTRL, 32'h1);
			wb_read(`REG_CTRL, rd);
			check_value("CTRL", rd, 32'h1);
			// the second frame is the first one that saw settled lines from its start.
			do begin
				wb_read(`REG_STATUS, rd);
			end while (16'(rd[15:0] - start_frame) < 16'd2);
			wb_write(`REG_CTRL, 32'h0);
			do begin
				wb_read(`REG_STATUS, rd);
			end while (rd[`STATUS_BUSY_BIT]);
			check_value("frame_count", {16'h0, rd[15:0]}, {16'h0, start_frame + 16'd3});
			for (int i = 0; i < NUM_INPUTS; i++) begin
				wb_read(`REG_COUNT_BASE + 8'(i), rd);
				check_value($sformatf("count[%0d]", i), rd, row.exp_count[i]);
			end
			for (int n = 0; n < NUM_BL * TAPS; n++) begin
				wb_read(`REG_CORR_BASE + 8'(n), rd);
				check_value($sformatf("corr[%0d]", n), rd, row.exp_corr[n]);
			end
			$display("row %0d: %s mode, integ_len %0d, %0d errors", r,
				row.edge_mode ? "edge" : "level", row.integ_len, errors - row_err);
		end
		errors = errors + dut.u_regs.u_bus_chk.fail_count + dut.u_timer.u_strobe_chk.fail_count;
		$display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int limit;
		#1;
		limit = run_budget();
		repeat (limit) @(posedge intclk);
		$display("watchdog: run did not finish within %0d clock cycles", limit);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- tb.f
+incdir+include
design/corr_pkg.sv
design/line_conditioner.sv
design/integration_timer.sv
design/pulse_counter.sv
design/lag_correlator.sv
design/wb_corr_regs.sv
design/correlator_top.sv
dv/corr_assertions.sv
dv/tb_correlator.sv
